// File: Bender.yml
package:
  name: gold_view

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/gold_view_pkg.sv
      - hdl/sprite_shader.sv
      - hdl/rect_painter.sv
      - hdl/item_table.sv
      - hdl/round_timer.sv
      - hdl/level_tracker.sv
      - hdl/view_ctrl.sv
      - hdl/gold_view_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/gold_view_chk.sv
      - tb/gold_view_tb.sv

// File: gold_view.f
+incdir+hdl
hdl/gold_view_pkg.sv
hdl/sprite_shader.sv
hdl/rect_painter.sv
hdl/item_table.sv
hdl/round_timer.sv
hdl/level_tracker.sv
hdl/view_ctrl.sv
hdl/gold_view_top.sv
tb/gold_view_chk.sv
tb/gold_view_tb.sv

// File: hdl/gold_view_macros.svh
//###########################################################################
// screen, sprite, item and timing constants shared by the view sequencer
// colours are 12-bit rgb, all nonzero so a zero write is always an error
//###########################################################################
`ifndef GOLD_VIEW_MACROS_SVH
`define GOLD_VIEW_MACROS_SVH
`default_nettype none

// frame buffer geometry
`define GV_SCREEN_W       320
`define GV_SCREEN_H       240
`define GV_X_W            9
`define GV_Y_W            8
`define GV_COLOR_W        12

// item sprites and the placement grid
`define GV_ITEM_SIZE      20
`define GV_CORNER         3
`define GV_FIELD_TOP      80
`define GV_N_GOLD         5
`define GV_N_STONE        7
`define GV_N_DIAMOND      3
`define GV_N_ITEMS        15
`define GV_IDX_W          4

// level, score and goal rule
`define GV_LEVEL_W        3
`define GV_SCORE_W        10
`define GV_GOAL_BASE      50
`define GV_GOAL_STEP      75

// round timer
`define GV_ROUND_SECONDS  60
`define GV_TIME_W         8

// palette
`define GV_COLOR_START    12'h1A4
`define GV_COLOR_BG       12'h842
`define GV_COLOR_OVER     12'hC00
`define GV_COLOR_NEXT     12'h0C8
`define GV_COLOR_GOLD     12'hFD0
`define GV_COLOR_STONE    12'h888
`define GV_COLOR_DIAMOND  12'h6EF

`default_nettype wire
`endif

// File: hdl/gold_view_pkg.sv
//###########################################################################
// types shared by the view sequencer blocks
// field widths come from the macros header
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

package gold_view_pkg;

	// one frame-buffer write
	typedef struct packed {
		logic [`GV_X_W-1:0]     x;
		logic [`GV_Y_W-1:0]     y;
		logic [`GV_COLOR_W-1:0] color;
		logic                   we;
	} pixel_t;

	// one paint job, origin plus size
	typedef struct packed {
		logic [`GV_X_W-1:0] x;
		logic [`GV_Y_W-1:0] y;
		logic [`GV_X_W-1:0] w;
		logic [`GV_Y_W-1:0] h;
	} rect_t;

	typedef enum logic [1:0] {
		ITEM_GOLD,
		ITEM_STONE,
		ITEM_DIAMOND
	} item_kind_e;

	typedef struct packed {
		logic [`GV_X_W-1:0] x;
		logic [`GV_Y_W-1:0] y;
		item_kind_e         kind;
		logic               present;
	} item_rec_t;

	typedef enum logic [2:0] {
		START_SCREEN,
		WAIT_GO,
		PAINT_BG,
		ITEM_FETCH,
		PAINT_ITEM,
		ROUND_CHECK,
		PAINT_NEXT,
		PAINT_OVER
	} view_state_e;

	typedef enum logic {
		FILL_FLAT,
		FILL_SPRITE
	} fill_src_e;

endpackage

`default_nettype wire

// File: hdl/gold_view_top.sv
//###########################################################################
// view sequencer top, pixel stream out one write per clock at most
// score and taken items come from the game logic outside
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module gold_view_top import gold_view_pkg::*; #(
	parameter int TICKS_PER_SEC = 50_000_000
) (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   go,
	input  logic                   item_taken,
	input  logic [`GV_IDX_W-1:0]   taken_index,
	input  logic [`GV_SCORE_W-1:0] score,
	output pixel_t                 pix,
	output logic [`GV_LEVEL_W-1:0] level,
	output logic [`GV_TIME_W-1:0]  time_left,
	output logic                   game_over
);

	logic                   paint_start;
	logic                   paint_done;
	rect_t                  job;
	logic [`GV_COLOR_W-1:0] flat_color;
	fill_src_e              fill_src;
	logic [`GV_X_W-1:0]     dx;
	logic [`GV_Y_W-1:0]     dy;
	logic [`GV_COLOR_W-1:0] shade_color;
	logic                   shade_opaque;
	logic [`GV_IDX_W-1:0]   item_index;
	item_rec_t              item;
	logic                   load_level;
	logic                   timer_run;
	logic                   timer_restart;
	logic                   time_up;
	logic                   level_up;
	logic                   level_clear;
	logic                   goal_met;

	view_ctrl u_ctrl (
		.clk(clk), .resetn(resetn), .go(go), .paint_done(paint_done), .item(item),
		.time_up(time_up), .goal_met(goal_met), .paint_start(paint_start), .job(job),
		.flat_color(flat_color), .fill_src(fill_src), .item_index(item_index),
		.load_level(load_level), .timer_run(timer_run), .timer_restart(timer_restart),
		.level_up(level_up), .level_clear(level_clear), .game_over(game_over)
	);

	rect_painter u_painter (
		.clk(clk), .resetn(resetn), .paint_start(paint_start), .job(job),
		.flat_color(flat_color), .fill_src(fill_src), .shade_color(shade_color),
		.shade_opaque(shade_opaque), .dx(dx), .dy(dy), .pix(pix), .paint_done(paint_done)
	);

	sprite_shader u_shader (
		.kind(item.kind), .dx(dx), .dy(dy),
		.shade_color(shade_color), .shade_opaque(shade_opaque)
	);

	item_table u_items (
		.clk(clk), .resetn(resetn), .load_level(load_level), .level(level),
		.item_taken(item_taken), .taken_index(taken_index), .item_index(item_index),
		.item(item)
	);

	round_timer #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_timer (
		.clk(clk), .resetn(resetn), .timer_run(timer_run), .timer_restart(timer_restart),
		.time_left(time_left), .time_up(time_up)
	);

	level_tracker u_level (
		.clk(clk), .resetn(resetn), .score(score), .level_up(level_up),
		.level_clear(level_clear), .level(level), .goal_met(goal_met)
	);

endmodule

`default_nettype wire

// File: hdl/item_table.sv
//###########################################################################
// item placement is a fixed hash of index and level, no storage
// only the present bits are state; indices past the last item read absent
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module item_table import gold_view_pkg::*; (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    load_level,
	input  logic [`GV_LEVEL_W-1:0]  level,
	input  logic                    item_taken,
	input  logic [`GV_IDX_W-1:0]    taken_index,
	input  logic [`GV_IDX_W-1:0]    item_index,
	output item_rec_t               item
);

	logic [`GV_N_ITEMS-1:0]      present;
	logic [2**`GV_IDX_W-1:0]     present_ext;
	logic [3:0]                  col;
	logic [2:0]                  row;
	item_kind_e                  kind;

	// mod 16 and mod 8 fall out of the narrow sums
	assign col = 4'd7 * item_index + 4'd3 * {1'b0, level};
	assign row = 3'd5 * item_index[2:0] + level;

	assign present_ext = {{(2**`GV_IDX_W - `GV_N_ITEMS){1'b0}}, present};

	always_comb begin
		if (item_index < `GV_IDX_W'(`GV_N_GOLD))
			kind = ITEM_GOLD;
		else if (item_index < `GV_IDX_W'(`GV_N_GOLD + `GV_N_STONE))
			kind = ITEM_STONE;
		else
			kind = ITEM_DIAMOND;
	end

	always_comb begin
		item.x = `GV_X_W'(col) * `GV_X_W'(`GV_ITEM_SIZE);
		item.y = `GV_Y_W'(`GV_FIELD_TOP) + `GV_Y_W'(row) * `GV_Y_W'(`GV_ITEM_SIZE);
		item.kind = kind;
		item.present = present_ext[item_index];
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			present <= '0;
		end else if (load_level) begin
			present <= '1;
		end else if (item_taken && taken_index < `GV_IDX_W'(`GV_N_ITEMS)) begin
			present[taken_index] <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: hdl/level_tracker.sv
//###########################################################################
// level register, wraps after 7
// goal_met is a registered compare and lags score by one clock
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module level_tracker (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [`GV_SCORE_W-1:0] score,
	input  logic                   level_up,
	input  logic                   level_clear,
	output logic [`GV_LEVEL_W-1:0] level,
	output logic                   goal_met
);

	logic [`GV_SCORE_W-1:0] goal;

	// highest goal is 575, fits the score width
	assign goal = `GV_SCORE_W'(`GV_GOAL_BASE) +
		`GV_SCORE_W'(`GV_GOAL_STEP) * `GV_SCORE_W'(level);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			level <= '0;
			goal_met <= 1'b0;
		end else begin
			if (level_clear)
				level <= '0;
			else if (level_up)
				level <= level + 1'b1;
			goal_met <= (score >= goal);
		end
	end

endmodule

`default_nettype wire

// File: hdl/rect_painter.sv
//###########################################################################
// walks one rectangle in raster order, one pixel per clock, no stall
// job w and h must be nonzero and stay steady until paint_done
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module rect_painter import gold_view_pkg::*; (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   paint_start,
	input  rect_t                  job,
	input  logic [`GV_COLOR_W-1:0] flat_color,
	input  fill_src_e              fill_src,
	input  logic [`GV_COLOR_W-1:0] shade_color,
	input  logic                   shade_opaque,
	output logic [`GV_X_W-1:0]     dx,
	output logic [`GV_Y_W-1:0]     dy,
	output pixel_t                 pix,
	output logic                   paint_done
);

	logic                   busy;
	logic                   active;
	logic                   last_x;
	logic                   last_y;
	logic [`GV_X_W-1:0]     px_q;
	logic [`GV_Y_W-1:0]     py_q;
	logic [`GV_COLOR_W-1:0] pc_q;
	logic                   we_q;

	// the start cycle already emits offset (0,0)
	assign active = paint_start || busy;
	assign last_x = (dx == job.w - 1'b1);
	assign last_y = (dy == job.h - 1'b1);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			busy <= 1'b0;
			dx <= '0;
			dy <= '0;
			we_q <= 1'b0;
			paint_done <= 1'b0;
		end else begin
			we_q <= active && (fill_src == FILL_FLAT || shade_opaque);
			paint_done <= active && last_x && last_y;
			busy <= active && !(last_x && last_y);
			if (active) begin
				if (last_x) begin
					dx <= '0;
					// counters park at zero for the next job
					dy <= last_y ? '0 : dy + 1'b1;
				end else begin
					dx <= dx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (active) begin
			px_q <= job.x + dx;
			py_q <= job.y + dy;
			pc_q <= (fill_src == FILL_SPRITE) ? shade_color : flat_color;
		end
	end

	assign pix = '{x: px_q, y: py_q, color: pc_q, we: we_q};

endmodule

`default_nettype wire

// File: hdl/round_timer.sv
//###########################################################################
// round countdown in seconds, TICKS_PER_SEC is the clock rate in Hz
// counts only while timer_run is high and stops at zero
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module round_timer #(
	parameter int TICKS_PER_SEC = 50_000_000
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  timer_run,
	input  logic                  timer_restart,
	output logic [`GV_TIME_W-1:0] time_left,
	output logic                  time_up
);

	localparam int PRESC_W = (TICKS_PER_SEC > 1) ? $clog2(TICKS_PER_SEC) : 1;

	logic [PRESC_W-1:0] presc;
	logic               tick;

	assign tick = (presc == PRESC_W'(TICKS_PER_SEC - 1));
	assign time_up = (time_left == '0);

	always_ff @(posedge clk) begin
		if (!resetn) begin
			presc <= '0;
			time_left <= `GV_TIME_W'(`GV_ROUND_SECONDS);
		end else if (timer_restart) begin
			presc <= '0;
			time_left <= `GV_TIME_W'(`GV_ROUND_SECONDS);
		end else if (timer_run && !time_up) begin
			if (tick) begin
				presc <= '0;
				time_left <= time_left - 1'b1;
			end else begin
				presc <= presc + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/sprite_shader.sv
//###########################################################################
// colour of one item pixel from its kind and offset in the 20x20 box
// corner squares are transparent, the rest is flat kind colour
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module sprite_shader import gold_view_pkg::*; (
	input  item_kind_e             kind,
	input  logic [`GV_X_W-1:0]     dx,
	input  logic [`GV_Y_W-1:0]     dy,
	output logic [`GV_COLOR_W-1:0] shade_color,
	output logic                   shade_opaque
);

	logic near_left;
	logic near_right;
	logic near_top;
	logic near_bottom;

	assign near_left = (dx < `GV_X_W'(`GV_CORNER));
	assign near_right = (dx >= `GV_X_W'(`GV_ITEM_SIZE - `GV_CORNER));
	assign near_top = (dy < `GV_Y_W'(`GV_CORNER));
	assign near_bottom = (dy >= `GV_Y_W'(`GV_ITEM_SIZE - `GV_CORNER));

	// transparent only where a column band meets a row band
	assign shade_opaque = !((near_left || near_right) && (near_top || near_bottom));

	always_comb begin
		case (kind)
			ITEM_STONE: shade_color = `GV_COLOR_STONE;
			ITEM_DIAMOND: shade_color = `GV_COLOR_DIAMOND;
			default: shade_color = `GV_COLOR_GOLD;
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/view_ctrl.sv
//###########################################################################
// game and paint sequencing, the only FSM of the view
// job, colour and fill source are held steady from paint_start to paint_done
// goal and time are looked at only after a full repaint
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module view_ctrl import gold_view_pkg::*; (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic                   go,
	input  logic                   paint_done,
	input  item_rec_t              item,
	input  logic                   time_up,
	input  logic                   goal_met,
	output logic                   paint_start,
	output rect_t                  job,
	output logic [`GV_COLOR_W-1:0] flat_color,
	output fill_src_e              fill_src,
	output logic [`GV_IDX_W-1:0]   item_index,
	output logic                   load_level,
	output logic                   timer_run,
	output logic                   timer_restart,
	output logic                   level_up,
	output logic                   level_clear,
	output logic                   game_over
);

	view_state_e state;
	view_state_e state_nxt;
	logic        launched;
	logic        painting;
	logic        round_start;
	logic        items_done;

	assign painting = (state == START_SCREEN) || (state == PAINT_BG) ||
		(state == PAINT_ITEM) || (state == PAINT_NEXT) || (state == PAINT_OVER);

	// one start pulse on the first cycle of each paint state
	assign paint_start = painting && !launched;

	assign timer_run = (state == PAINT_BG) || (state == ITEM_FETCH) ||
		(state == PAINT_ITEM) || (state == ROUND_CHECK);

	assign items_done = (item_index >= `GV_IDX_W'(`GV_N_ITEMS));

	// round start reloads the table and the timer together
	assign timer_restart = round_start;
	assign load_level = round_start;

	always_comb begin
		job = '{x: '0, y: '0, w: `GV_X_W'(`GV_SCREEN_W), h: `GV_Y_W'(`GV_SCREEN_H)};
		fill_src = FILL_FLAT;
		flat_color = `GV_COLOR_BG;
		case (state)
			START_SCREEN: flat_color = `GV_COLOR_START;
			PAINT_NEXT: flat_color = `GV_COLOR_NEXT;
			PAINT_OVER: flat_color = `GV_COLOR_OVER;
			PAINT_ITEM: begin
				job = '{x: item.x, y: item.y, w: `GV_X_W'(`GV_ITEM_SIZE),
					h: `GV_Y_W'(`GV_ITEM_SIZE)};
				fill_src = FILL_SPRITE;
			end
			default: ;
		endcase
	end

	always_comb begin
		state_nxt = state;
		round_start = 1'b0;
		level_up = 1'b0;
		level_clear = 1'b0;
		case (state)
			START_SCREEN: if (paint_done) state_nxt = WAIT_GO;
			WAIT_GO: begin
				if (go) begin
					state_nxt = PAINT_BG;
					round_start = 1'b1;
					level_clear = 1'b1;
				end
			end
			PAINT_BG: if (paint_done) state_nxt = ITEM_FETCH;
			ITEM_FETCH: begin
				if (items_done)
					state_nxt = ROUND_CHECK;
				else if (item.present)
					state_nxt = PAINT_ITEM;
			end
			PAINT_ITEM: if (paint_done) state_nxt = ITEM_FETCH;
			ROUND_CHECK: begin
				// next level wins over game over
				if (goal_met) begin
					state_nxt = PAINT_NEXT;
					level_up = 1'b1;
				end else if (time_up) begin
					state_nxt = PAINT_OVER;
				end else begin
					state_nxt = PAINT_BG;
				end
			end
			PAINT_NEXT: begin
				if (paint_done) begin
					state_nxt = PAINT_BG;
					round_start = 1'b1;
				end
			end
			PAINT_OVER: if (paint_done) state_nxt = WAIT_GO;
			default: state_nxt = START_SCREEN;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= START_SCREEN;
			launched <= 1'b0;
			item_index <= '0;
			game_over <= 1'b0;
		end else begin
			state <= state_nxt;
			if (paint_done)
				launched <= 1'b0;
			else if (paint_start)
				launched <= 1'b1;
			// absent items are skipped one per cycle
			if (state == PAINT_BG)
				item_index <= '0;
			else if ((state == ITEM_FETCH && !items_done && !item.present) ||
				(state == PAINT_ITEM && paint_done))
				item_index <= item_index + 1'b1;
			if (state == PAINT_OVER && paint_done)
				game_over <= 1'b1;
			else if (state == WAIT_GO && go)
				game_over <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: tb/gold_view_chk.sv
//###########################################################################
// concurrent checks on the ports of gold_view_top, attached with bind
// fail_count is read by the testbench when the run ends
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module gold_view_chk import gold_view_pkg::*; (
	input logic                   clk,
	input logic                   resetn,
	input pixel_t                 pix,
	input logic [`GV_LEVEL_W-1:0] level,
	input logic [`GV_TIME_W-1:0]  time_left,
	input logic                   game_over
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// every write is a drawn colour on the visible screen
	write_on_screen: assert property (@(posedge clk) disable iff (!resetn)
		pix.we |-> (pix.color != '0) && (pix.x < `GV_X_W'(`GV_SCREEN_W)) &&
		(pix.y < `GV_Y_W'(`GV_SCREEN_H)))
	else begin
		$error("frame buffer write off screen or with a zero colour");
		fail_count++;
	end

	reset_clears: assert property (@(posedge clk)
		!resetn |=> !pix.we && !game_over && (level == '0))
	else begin
		$error("outputs not cleared by reset");
		fail_count++;
	end

	// the game-over screen is finished before the flag rises
	quiet_in_game_over: assert property (@(posedge clk) disable iff (!resetn)
		game_over |-> !pix.we)
	else begin
		$error("frame buffer written while game_over is high");
		fail_count++;
	end

	// seconds only count down by one or reload
	time_step: assert property (@(posedge clk) disable iff (!resetn)
		(time_left != $past(time_left)) |->
		(time_left == $past(time_left) - 1'b1) ||
		(time_left == `GV_TIME_W'(`GV_ROUND_SECONDS)))
	else begin
		$error("time_left jumped to an unexpected value");
		fail_count++;
	end

	level_step: assert property (@(posedge clk) disable iff (!resetn)
		(level != $past(level)) |-> (level == $past(level) + 1'b1) || (level == '0))
	else begin
		$error("level moved by other than one step or a clear");
		fail_count++;
	end

endmodule

bind gold_view_top gold_view_chk u_chk (
	.clk(clk),
	.resetn(resetn),
	.pix(pix),
	.level(level),
	.time_left(time_left),
	.game_over(game_over)
);

`default_nettype wire

// File: tb/gold_view_tb.sv
//###########################################################################
// runs start screen, a won level 0 round, a lost level 1 round and a restart
// TICKS_PER_SEC is 200 so the round timer expires within one repaint
//###########################################################################
`include "gold_view_macros.svh"
`default_nettype none

module gold_view_tb import gold_view_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WRITE_TIMEOUT = 2000;
	localparam int EVENT_TIMEOUT = 2000;
	// opaque pixels of one sprite
	localparam int SPRITE_WRITES = `GV_ITEM_SIZE * `GV_ITEM_SIZE - 4 * `GV_CORNER * `GV_CORNER;

	logic                   clk;
	logic                   resetn;
	logic                   go;
	logic                   item_taken;
	logic [`GV_IDX_W-1:0]   taken_index;
	logic [`GV_SCORE_W-1:0] score;
	pixel_t                 pix;
	logic [`GV_LEVEL_W-1:0] level;
	logic [`GV_TIME_W-1:0]  time_left;
	logic                   game_over;

	int                     mismatches;
	int                     timeouts;
	bit                     watch_time;
	logic [`GV_TIME_W-1:0]  prev_time;

	gold_view_top #(.TICKS_PER_SEC(200)) UUT (
		.clk(clk), .resetn(resetn), .go(go), .item_taken(item_taken),
		.taken_index(taken_index), .score(score), .pix(pix), .level(level),
		.time_left(time_left), .game_over(game_over)
	);

	always #4 clk = ~clk;

	// time_left may only fall while a round is watched
	always @(negedge clk) begin
		if (watch_time) begin
			assert (time_left <= prev_time) else begin
				mismatches++;
				$display("MISMATCH time_left: rose from %h to %h", prev_time, time_left);
			end
		end
		prev_time = time_left;
	end

	function automatic int item_x(input int i, input int lvl);
		return `GV_ITEM_SIZE * ((7 * i + 3 * lvl) % 16);
	endfunction

	function automatic int item_y(input int i, input int lvl);
		return `GV_FIELD_TOP + `GV_ITEM_SIZE * ((5 * i + lvl) % 8);
	endfunction

	function automatic logic [`GV_COLOR_W-1:0] kind_color(input int i);
		if (i < `GV_N_GOLD)
			return `GV_COLOR_GOLD;
		else if (i < `GV_N_GOLD + `GV_N_STONE)
			return `GV_COLOR_STONE;
		return `GV_COLOR_DIAMOND;
	endfunction

	task automatic wait_write(output pixel_t p, output bit ok);
		ok = 1'b0;
		p = '0;
		for (int n = 0; n < WRITE_TIMEOUT; n++) begin
			@(negedge clk);
			if (pix.we) begin
				p = pix;
				ok = 1'b1;
				return;
			end
		end
		timeouts++;
		$display("timeout: no frame buffer write for %0d cycles", WRITE_TIMEOUT);
	endtask

	// full screen in raster order from (0,0) in one flat colour
	task automatic collect_screen(input logic [`GV_COLOR_W-1:0] color, output bit ok);
		pixel_t p;
		ok = 1'b1;
		for (int y = 0; y < `GV_SCREEN_H; y++) begin
			for (int x = 0; x < `GV_SCREEN_W; x++) begin
				wait_write(p, ok);
				if (!ok)
					return;
				assert (p.x == x && p.y == y) else begin
					mismatches++;
					$display("MISMATCH pix.x,pix.y: expected %h,%h got %h,%h", x, y, p.x, p.y);
				end
				assert (p.color == color) else begin
					mismatches++;
					$display("MISMATCH pix.color: expected %h got %h", color, p.color);
				end
			end
		end
	endtask

	// item pass of one repaint
	// taken is -1 when no item was removed
	task automatic check_items(input int lvl, input int taken, output bit ok);
		pixel_t p;
		int     hit;
		int     ox;
		int     oy;
		int     total;
		bit     corner;
		total = SPRITE_WRITES * ((taken >= 0) ? `GV_N_ITEMS - 1 : `GV_N_ITEMS);
		ok = 1'b1;
		for (int n = 0; n < total; n++) begin
			wait_write(p, ok);
			if (!ok)
				return;
			hit = -1;
			for (int i = 0; i < `GV_N_ITEMS; i++) begin
				if (p.x >= item_x(i, lvl) && p.x < item_x(i, lvl) + `GV_ITEM_SIZE &&
					p.y >= item_y(i, lvl) && p.y < item_y(i, lvl) + `GV_ITEM_SIZE)
					hit = i;
			end
			assert (hit >= 0 && hit != taken) else begin
				mismatches++;
				$display("MISMATCH pix.x,pix.y: %h,%h outside every present item", p.x, p.y);
			end
			if (hit >= 0) begin
				ox = p.x - item_x(hit, lvl);
				oy = p.y - item_y(hit, lvl);
				corner = (ox < `GV_CORNER || ox >= `GV_ITEM_SIZE - `GV_CORNER) &&
					(oy < `GV_CORNER || oy >= `GV_ITEM_SIZE - `GV_CORNER);
				assert (!corner) else begin
					mismatches++;
					$display("MISMATCH pix.we: expected 0 got 1 at corner %h,%h", p.x, p.y);
				end
				assert (p.color == kind_color(hit)) else begin
					mismatches++;
					$display("MISMATCH pix.color: expected %h got %h", kind_color(hit), p.color);
				end
			end
		end
	endtask

	task automatic wait_time_reload(output bit ok);
		ok = 1'b0;
		for (int n = 0; n < EVENT_TIMEOUT; n++) begin
			@(negedge clk);
			if (time_left == `GV_TIME_W'(`GV_ROUND_SECONDS)) begin
				ok = 1'b1;
				return;
			end
		end
		timeouts++;
		$display("timeout: time_left did not return to the round length");
	endtask

	task automatic wait_game_over(input bit value, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < EVENT_TIMEOUT; n++) begin
			@(negedge clk);
			if (game_over == value) begin
				ok = 1'b1;
				return;
			end
		end
		timeouts++;
		$display("timeout: game_over did not become %0d", value);
	endtask

	task automatic run_game();
		bit     ok;
		bit     ok_bg;
		int     taken;
		pixel_t p;
		@(negedge clk);
		assert (!game_over && level == '0) else begin
			mismatches++;
			$display("MISMATCH game_over,level: expected 0,0 got %h,%h", game_over, level);
		end
		collect_screen(`GV_COLOR_START, ok);
		if (!ok)
			return;
		// start screen holds without writes until go
		for (int n = 0; n < 200; n++) begin
			@(negedge clk);
			assert (!pix.we) else begin
				mismatches++;
				$display("MISMATCH pix.we: expected 0 got 1 before go");
			end
		end
		taken = $urandom % `GV_N_ITEMS;
		// level 0 with score at its goal and one item taken during the background
		fork
			begin
				@(posedge clk);
				score <= `GV_SCORE_W'(`GV_GOAL_BASE);
				go <= 1'b1;
				@(posedge clk);
				go <= 1'b0;
				item_taken <= 1'b1;
				taken_index <= `GV_IDX_W'(taken);
				@(posedge clk);
				item_taken <= 1'b0;
			end
			collect_screen(`GV_COLOR_BG, ok);
		join
		if (!ok)
			return;
		check_items(0, taken, ok);
		if (!ok)
			return;
		collect_screen(`GV_COLOR_NEXT, ok);
		if (!ok)
			return;
		assert (level == `GV_LEVEL_W'(1)) else begin
			mismatches++;
			$display("MISMATCH level: expected 1 got %h", level);
		end
		// level 1 with zero score so the timer ends the round
		fork
			begin
				@(posedge clk);
				score <= '0;
				wait_time_reload(ok);
				@(posedge clk);
				watch_time = ok;
			end
			collect_screen(`GV_COLOR_BG, ok_bg);
		join
		if (!ok || !ok_bg)
			return;
		// 60 s at 200 ticks each is far shorter than one background pass
		assert (time_left == '0) else begin
			mismatches++;
			$display("MISMATCH time_left: expected 00 got %h", time_left);
		end
		check_items(1, -1, ok);
		watch_time = 1'b0;
		if (!ok)
			return;
		collect_screen(`GV_COLOR_OVER, ok);
		if (!ok)
			return;
		wait_game_over(1'b1, ok);
		if (!ok)
			return;
		@(posedge clk);
		go <= 1'b1;
		@(posedge clk);
		go <= 1'b0;
		wait_game_over(1'b0, ok);
		if (!ok)
			return;
		assert (level == '0) else begin
			mismatches++;
			$display("MISMATCH level: expected 0 got %h", level);
		end
		wait_write(p, ok);
		if (!ok)
			return;
		assert (p.x == '0 && p.y == '0 && p.color == `GV_COLOR_BG) else begin
			mismatches++;
			$display("MISMATCH pix: expected 0,0,%h got %h,%h,%h", `GV_COLOR_BG, p.x, p.y,
				p.color);
		end
	endtask

	initial begin
		void'($urandom(32'ha6d5a03a));
		clk = 1'b0;
		resetn = 1'b0;
		go = 1'b0;
		item_taken = 1'b0;
		taken_index = '0;
		score = '0;
		mismatches = 0;
		timeouts = 0;
		watch_time = 1'b0;
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		run_game();
		$display("mismatches %0d, timeouts %0d, assertion failures %0d", mismatches, timeouts,
			UUT.u_chk.fail_count);
		if (mismatches == 0 && timeouts == 0 && UUT.u_chk.fail_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
